/* all.f */
+incdir+hw
hw/rob_uop_pkg.sv
hw/rob_ctrl_pkg.sv
hw/rob_enq_ctrl.sv
hw/rob_entry_array.sv
hw/rob_commit_ctrl.sv
hw/rob_flush_walk.sv
hw/rob_top.sv
bench/rob_asserts.sv
bench/rob_tb.sv

/* bench/rob_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module rob_asserts (
    input wire                            clock,
    input wire                            reset_n,
    input wire rob_uop_pkg::commit_t      commit,
    input wire rob_ctrl_pkg::walk_lane_t  walk0,
    input wire rob_ctrl_pkg::walk_lane_t  walk1,
    input wire rob_ctrl_pkg::flush_req_t  flush,
    input wire rob_ctrl_pkg::rob_state_e  rob_state
);

    // nothing retires in the cycle after a flush
    a_commit_idle: assert property (@(posedge clock) disable iff (!reset_n)
        $past(flush.valid) |-> !commit.valid)
        else $error("commit while not idle");

    // walk lanes only ever follow a rollback
    a_walk_state: assert property (@(posedge clock) disable iff (!reset_n)
        (walk0.valid || walk1.valid) |-> rob_state == rob_ctrl_pkg::walk &&
                                         $past(rob_state) != rob_ctrl_pkg::idle)
        else $error("walk lane outside walk state");

    // flush enters rollback one edge later
    a_flush_rollback: assert property (@(posedge clock) disable iff (!reset_n)
        flush.valid |=> rob_state == rob_ctrl_pkg::rollback)
        else $error("flush not followed by rollback");

endmodule

bind rob_top rob_asserts u_asserts (
    .clock(clock), .reset_n(reset_n),
    .commit(commit), .walk0(walk0), .walk1(walk1),
    .flush(flush), .rob_state(rob_state)
);

`default_nettype wire

/* bench/rob_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rob_settings.svh"

module rob_tb;

    localparam int NROWS = 9;

    logic clock;
    logic reset_n;
    rob_uop_pkg::enq_lane_t   enq0;
    rob_uop_pkg::enq_lane_t   enq1;
    rob_ctrl_pkg::wb_port_t   int_wb;
    rob_ctrl_pkg::wb_port_t   mem_wb;
    rob_ctrl_pkg::flush_req_t flush;
    rob_uop_pkg::robid_t      disp_robid;
    rob_uop_pkg::commit_t     commit;
    rob_ctrl_pkg::walk_lane_t walk0;
    rob_ctrl_pkg::walk_lane_t walk1;
    rob_ctrl_pkg::rob_state_e rob_state;

    // name, uop count, flush offset (-1 none), mmio on the memory port
    string row_name [NROWS] = '{"pairs", "odd_count", "mmio_mix", "flush_mid", "after_flush",
                                "flush_head", "deep", "flush_deep", "wrap_tail"};
    int    row_count [NROWS] = '{10, 7, 12, 14, 9, 6, 60, 40, 50};
    int    row_flush [NROWS] = '{-1, -1, -1, 5, -1, 0, -1, 30, -1};
    bit    row_mmio  [NROWS] = '{0, 0, 1, 0, 1, 0, 1, 0, 1};

    rob_uop_pkg::uop_t   exp_uop  [`ROB_DEPTH];
    logic                exp_skip [`ROB_DEPTH];
    logic                wb_sent  [`ROB_DEPTH];
    rob_uop_pkg::robid_t exp_enq;
    rob_uop_pkg::robid_t exp_deq;
    logic [12:0]         exp_walk [$];
    logic [12:0]         got_walk [$];
    logic [31:0]         rng;
    string               cur_name;
    int                  errors;
    int                  commits_seen;
    int                  cycles;
    int                  limit;

    rob_top DUT (
        .clock(clock), .reset_n(reset_n), .enq0(enq0), .enq1(enq1),
        .int_wb(int_wb), .mem_wb(mem_wb), .flush(flush), .disp_robid(disp_robid),
        .commit(commit), .walk0(walk0), .walk1(walk1), .rob_state(rob_state)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string what, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
            errors++;
        end
    endtask

    function automatic rob_uop_pkg::uop_t make_uop(input rob_uop_pkg::robid_t id,
                                                    input logic [31:0] rnd);
        rob_uop_pkg::uop_t u;
        u.pc         = 32'h8000_0000 + {rnd[15:0], 2'b00};
        u.instr      = rnd ^ 32'h0000_0013;
        u.lrd        = rnd[20:16];
        u.prd        = {rnd[23:21], id[3:0]};
        u.old_prd    = rnd[30:24];
        u.need_to_wb = (rnd[31:29] != 3'd0);  // some entries have no destination
        return u;
    endfunction

    // commit and walk observer sampling on the edge
    always @(posedge clock) begin
        if (reset_n && commit.valid) begin
            check_value("commit robid", 128'(exp_deq), 128'(commit.robid));
            if (!wb_sent[exp_deq[`ROB_IDX_W-1:0]]) begin
                $display("%s: robid %0h committed without a writeback", cur_name, commit.robid);
                errors++;
            end
            check_value("commit uop", 128'(exp_uop[exp_deq[`ROB_IDX_W-1:0]]), 128'(commit.uop));
            check_value("commit skip", 128'(exp_skip[exp_deq[`ROB_IDX_W-1:0]]),
                        128'(commit.skip));
            exp_deq = exp_deq + 1'b1;
            commits_seen++;
        end
        if (reset_n && walk0.valid) got_walk.push_back({walk0.lrd, walk0.prd, walk0.complete});
        if (reset_n && walk1.valid) got_walk.push_back({walk1.lrd, walk1.prd, walk1.complete});
    end

    always @(posedge clock) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic run_row(input int r);
        int                  n;
        int                  fl;
        int                  tmp;
        int                  j;
        int                  order [$];
        int                  survivors;
        int                  err_start;
        rob_uop_pkg::robid_t base;
        rob_uop_pkg::robid_t id;
        rob_uop_pkg::robid_t exp_id;
        rob_uop_pkg::uop_t   u;
        n = row_count[r];
        fl = row_flush[r];
        cur_name = row_name[r];
        err_start = errors;
        base = exp_enq;
        // enqueue two per cycle with lane 1 only beside lane 0
        for (int off = 0; off < n; off += 2) begin
            @(posedge clock);
            if (off > 0) begin
                exp_id = base + 7'(off - 2);
                check_value("disp_robid", 128'(exp_id), 128'(disp_robid));
            end
            for (int l = 0; l < 2; l++) begin
                id = base + 7'(off + l);
                rng = xorshift32(rng);
                u = make_uop(id, rng);
                if (off + l < n) begin
                    exp_uop[id[`ROB_IDX_W-1:0]] = u;
                    wb_sent[id[`ROB_IDX_W-1:0]] = 1'b0;
                end
                if (l == 0) enq0 <= '{valid: 1'b1, uop: u};
                else enq1 <= '{valid: (off + 1 < n), uop: u};
            end
        end
        @(posedge clock);
        exp_id = base + 7'((n - 1) & ~1);
        check_value("disp_robid", 128'(exp_id), 128'(disp_robid));
        enq0.valid <= 1'b0;
        enq1.valid <= 1'b0;
        exp_enq = base + 7'(n);
        // shuffled writeback order; the head waits in flush rows
        for (int off = (fl >= 0) ? 1 : 0; off < n; off++) order.push_back(off);
        for (int k = order.size() - 1; k > 0; k--) begin
            rng = xorshift32(rng);
            j = int'(rng % (k + 1));
            tmp = order[k];
            order[k] = order[j];
            order[j] = tmp;
        end
        foreach (order[k]) begin
            id = base + 7'(order[k]);
            @(posedge clock);
            int_wb.valid <= 1'b0;
            mem_wb.valid <= 1'b0;
            if (order[k][0]) begin
                int_wb <= '{valid: 1'b1, robid: id, mmio: 1'b0};
                exp_skip[id[`ROB_IDX_W-1:0]] = 1'b0;
            end else begin
                mem_wb <= '{valid: 1'b1, robid: id, mmio: row_mmio[r]};
                exp_skip[id[`ROB_IDX_W-1:0]] = row_mmio[r];
            end
            wb_sent[id[`ROB_IDX_W-1:0]] = 1'b1;
        end
        @(posedge clock);
        int_wb.valid <= 1'b0;
        mem_wb.valid <= 1'b0;
        survivors = n;
        if (fl >= 0) begin
            exp_walk.delete();
            got_walk.delete();
            for (int off = 0; off <= fl; off++) begin
                u = exp_uop[7'(base + 7'(off)) % `ROB_DEPTH];
                if (u.need_to_wb) exp_walk.push_back({u.lrd, u.prd, (off != 0)});
            end
            @(posedge clock);
            flush <= '{valid: 1'b1, robid: base + 7'(fl)};
            @(posedge clock);
            flush.valid <= 1'b0;
            for (int off = fl + 1; off < n; off++) wb_sent[7'(base + 7'(off)) % `ROB_DEPTH] = 1'b0;
            @(posedge clock);
            while (rob_state != rob_ctrl_pkg::idle) @(posedge clock);
            check_value("walk count", 128'(exp_walk.size()), 128'(got_walk.size()));
            foreach (exp_walk[k]) begin
                if (k < got_walk.size()) check_value("walk lane", 128'(exp_walk[k]),
                                                     128'(got_walk[k]));
            end
            survivors = fl + 1;
            exp_enq = base + 7'(fl + 1);
            // head writeback lets the survivors retire
            mem_wb <= '{valid: 1'b1, robid: base, mmio: 1'b0};
            exp_skip[base[`ROB_IDX_W-1:0]] = 1'b0;
            wb_sent[base[`ROB_IDX_W-1:0]] = 1'b1;
            @(posedge clock);
            mem_wb.valid <= 1'b0;
        end
        while (commits_seen < survivors) @(posedge clock);
        commits_seen = 0;
        if (errors == err_start) $display("test %s: ok", cur_name);
        else $display("test %s: %0d errors", cur_name, errors - err_start);
    endtask

    initial begin
        int failed_rows;
        int e0;
        errors = 0;
        cycles = 0;
        commits_seen = 0;
        failed_rows = 0;
        rng = 32'hd38a_615f;
        exp_enq = '0;
        exp_deq = '0;
        reset_n = 1'b0;
        enq0 = '0;
        enq1 = '0;
        int_wb = '0;
        mem_wb = '0;
        flush = '0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            wb_sent[i] = 1'b0;
            exp_skip[i] = 1'b0;
        end
        limit = 20;
        for (int r = 0; r < NROWS; r++) limit += (3 * row_count[r] + 20) * 4;
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);
        cur_name = "reset";
        check_value("state", 128'(rob_ctrl_pkg::idle), 128'(rob_state));
        check_value("disp_robid", 128'(0), 128'(disp_robid));
        check_value("commit valid", 128'(0), 128'(commit.valid));
        check_value("walk0 valid", 128'(0), 128'(walk0.valid));
        check_value("walk1 valid", 128'(0), 128'(walk1.valid));
        for (int r = 0; r < NROWS; r++) begin
            e0 = errors;
            run_row(r);
            if (errors != e0) failed_rows++;
        end
        $display("tests %0d, failed %0d, errors %0d", NROWS, failed_rows, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/rob_commit_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module rob_commit_ctrl (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire rob_ctrl_pkg::entry_view_t head_view,
    input  wire rob_ctrl_pkg::rob_state_e  state,
    input  wire                          flush_valid,
    output rob_uop_pkg::robid_t          deq_ptr,
    output rob_uop_pkg::commit_t         commit,
    output logic                         retire
);

    localparam rob_uop_pkg::robid_t robid_one = 1;

    // head must be done, and nothing may retire while a flush is in flight
    assign retire = head_view.valid && head_view.complete &&
                    (state == rob_ctrl_pkg::idle) && !flush_valid;

    always_comb begin
        commit.valid = retire;
        commit.uop   = head_view.uop;
        commit.robid = deq_ptr;        // full robid, wrap bit included
        commit.skip  = head_view.skip;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            deq_ptr <= '0;
        end else if (retire) begin
            deq_ptr <= deq_ptr + robid_one;  // one retire per cycle at most
        end
    end

endmodule

`default_nettype wire

/* hw/rob_ctrl_pkg.sv */
`default_nettype none

package rob_ctrl_pkg;

    typedef enum logic [1:0] {
        idle     = 2'd0,
        rollback = 2'd1,
        walk     = 2'd2
    } rob_state_e;

    typedef struct packed {
        logic                 valid;
        rob_uop_pkg::robid_t robid;
        logic                 mmio;  // only meaningful on the memory port
    } wb_port_t;

    typedef struct packed {
        logic                 valid;
        rob_uop_pkg::robid_t robid;
    } flush_req_t;

    // one rename table repair slot
    typedef struct packed {
        logic                valid;
        rob_uop_pkg::lreg_t lrd;
        rob_uop_pkg::preg_t prd;
        logic                complete;
    } walk_lane_t;

    typedef struct packed {
        logic               valid;
        logic               complete;
        logic               skip;
        rob_uop_pkg::uop_t uop;
    } entry_view_t;

endpackage

`default_nettype wire

/* hw/rob_enq_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rob_settings.svh"

module rob_enq_ctrl (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire rob_uop_pkg::enq_lane_t enq0,
    input  wire rob_uop_pkg::enq_lane_t enq1,
    input  wire rob_ctrl_pkg::rob_state_e state,
    input  wire rob_uop_pkg::robid_t  restore_robid,
    output logic                     wr0,
    output logic                     wr1,
    output rob_uop_pkg::rob_idx_t    wr0_idx,
    output rob_uop_pkg::rob_idx_t    wr1_idx,
    output rob_uop_pkg::robid_t      enq_ptr
);

    localparam rob_uop_pkg::robid_t robid_one = 1;

    logic                 accept0;
    logic                 accept1;
    rob_uop_pkg::robid_t enq_num;

    // no new work while the rename table is being repaired
    assign accept0 = enq0.valid && (state == rob_ctrl_pkg::idle);
    // lane 1 never goes alone, keeps program order dense
    assign accept1 = accept0 && enq1.valid;

    assign wr0     = accept0;
    assign wr1     = accept1;
    assign wr0_idx = enq_ptr[`ROB_IDX_W-1:0];
    assign wr1_idx = wr0_idx + 1'b1;  // wraps inside the index bits

    assign enq_num = {{`ROB_IDX_W{1'b0}}, accept0} + {{`ROB_IDX_W{1'b0}}, accept1};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr <= '0;
        end else if (state == rob_ctrl_pkg::rollback) begin
            enq_ptr <= restore_robid + robid_one;  // first slot after the flusher
        end else begin
            enq_ptr <= enq_ptr + enq_num;
        end
    end

endmodule

`default_nettype wire

/* hw/rob_entry_array.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rob_settings.svh"

module rob_entry_array (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire                         wr0,
    input  wire                         wr1,
    input  wire rob_uop_pkg::rob_idx_t  wr0_idx,
    input  wire rob_uop_pkg::rob_idx_t  wr1_idx,
    input  wire rob_uop_pkg::uop_t      wr0_uop,
    input  wire rob_uop_pkg::uop_t      wr1_uop,
    input  wire rob_ctrl_pkg::wb_port_t int_wb,
    input  wire rob_ctrl_pkg::wb_port_t mem_wb,
    input  wire                         retire,
    input  wire rob_uop_pkg::rob_idx_t  retire_idx,
    input  wire [`ROB_DEPTH-1:0]        squash_mask,
    input  wire rob_uop_pkg::rob_idx_t  head_idx,
    input  wire rob_uop_pkg::rob_idx_t  walk_idx,
    output rob_ctrl_pkg::entry_view_t   head_view,
    output rob_ctrl_pkg::entry_view_t   walk0_view,
    output rob_ctrl_pkg::entry_view_t   walk1_view
);

    logic [`ROB_DEPTH-1:0] valid_vec;
    logic [`ROB_DEPTH-1:0] complete_vec;
    logic [`ROB_DEPTH-1:0] skip_vec;
    rob_uop_pkg::uop_t     uop_vec [`ROB_DEPTH];
    rob_uop_pkg::rob_idx_t walk1_idx;

    for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_entry
        localparam rob_uop_pkg::rob_idx_t slot = rob_uop_pkg::rob_idx_t'(i);

        logic              wr0_hit;
        logic              wr1_hit;
        logic              int_hit;
        logic              mem_hit;
        logic              clear;
        logic              valid_q;
        logic              complete_q;
        logic              skip_q;
        rob_uop_pkg::uop_t uop_q;

        assign wr0_hit = wr0 && (wr0_idx == slot);
        assign wr1_hit = wr1 && (wr1_idx == slot);
        // writeback is addressed by index, wrap bit is ignored
        assign int_hit = int_wb.valid && (int_wb.robid[`ROB_IDX_W-1:0] == slot);
        assign mem_hit = mem_wb.valid && (mem_wb.robid[`ROB_IDX_W-1:0] == slot);
        assign clear   = (retire && (retire_idx == slot)) || squash_mask[i];

        always_ff @(posedge clock) begin
            if (wr0_hit) begin
                uop_q <= wr0_uop;
            end else if (wr1_hit) begin
                uop_q <= wr1_uop;
            end
        end

        // later statements win on the same edge
        always_ff @(posedge clock or negedge reset_n) begin
            if (!reset_n) begin
                valid_q    <= 1'b0;
                complete_q <= 1'b0;
                skip_q     <= 1'b0;
            end else begin
                if (clear) begin
                    valid_q <= 1'b0;
                end
                if (wr0_hit || wr1_hit) begin  // fresh entry
                    valid_q    <= 1'b1;
                    complete_q <= 1'b0;
                    skip_q     <= 1'b0;
                end
                if (int_hit || mem_hit) begin
                    complete_q <= 1'b1;
                end
                if (mem_hit && mem_wb.mmio) begin
                    skip_q <= 1'b1;
                end
            end
        end

        assign valid_vec[i]    = valid_q;
        assign complete_vec[i] = complete_q;
        assign skip_vec[i]     = skip_q;
        assign uop_vec[i]      = uop_q;
    end

    function automatic rob_ctrl_pkg::entry_view_t view_of(input rob_uop_pkg::rob_idx_t idx);
        rob_ctrl_pkg::entry_view_t v;
        v.valid    = valid_vec[idx];
        v.complete = complete_vec[idx];
        v.skip     = skip_vec[idx];
        v.uop      = uop_vec[idx];
        return v;
    endfunction

    assign walk1_idx = walk_idx + 1'b1;

    always_comb begin
        head_view  = view_of(head_idx);
        walk0_view = view_of(walk_idx);
        walk1_view = view_of(walk1_idx);  // second walk slot
    end

endmodule

`default_nettype wire

/* hw/rob_flush_walk.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rob_settings.svh"

module rob_flush_walk (
    input  wire                            clock,
    input  wire                            reset_n,
    input  wire rob_ctrl_pkg::flush_req_t  flush,
    input  wire rob_uop_pkg::robid_t       enq_ptr,
    input  wire rob_uop_pkg::robid_t       deq_ptr,
    input  wire rob_ctrl_pkg::entry_view_t walk0_view,
    input  wire rob_ctrl_pkg::entry_view_t walk1_view,
    output rob_ctrl_pkg::rob_state_e       state,
    output rob_uop_pkg::robid_t            restore_robid,
    output logic [`ROB_DEPTH-1:0]          squash_mask,
    output rob_uop_pkg::rob_idx_t          walk_idx,
    output rob_ctrl_pkg::walk_lane_t       walk0,
    output rob_ctrl_pkg::walk_lane_t       walk1
);

    rob_ctrl_pkg::rob_state_e state_nxt;
    rob_uop_pkg::robid_t      flush_robid_q;
    rob_uop_pkg::rob_idx_t    flush_idx;
    rob_uop_pkg::rob_idx_t    enq_idx;
    rob_uop_pkg::rob_idx_t    walk_ptr;
    logic                     in_walk;

    always_comb begin
        state_nxt = state;
        case (state)
            rob_ctrl_pkg::idle: begin
                if (flush.valid) state_nxt = rob_ctrl_pkg::rollback;
            end
            rob_ctrl_pkg::rollback: begin
                if (!flush.valid) state_nxt = rob_ctrl_pkg::walk;
            end
            rob_ctrl_pkg::walk: begin
                if (flush.valid) begin
                    state_nxt = rob_ctrl_pkg::rollback;  // restart on a newer flush
                end else if (!walk1_view.valid) begin
                    state_nxt = rob_ctrl_pkg::idle;      // ran past the youngest survivor
                end
            end
            default: state_nxt = rob_ctrl_pkg::idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= rob_ctrl_pkg::idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clock) begin
        if (flush.valid) begin
            flush_robid_q <= flush.robid;
        end
    end

    assign restore_robid = flush_robid_q;
    assign flush_idx     = flush_robid_q[`ROB_IDX_W-1:0];
    assign enq_idx       = enq_ptr[`ROB_IDX_W-1:0];

    // kill (flush, enq) in index space, second branch covers the wrap
    always_comb begin
        squash_mask = '0;
        if (state == rob_ctrl_pkg::rollback) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (enq_idx > flush_idx) begin
                    squash_mask[i] = (rob_uop_pkg::rob_idx_t'(i) > flush_idx) &&
                                     (rob_uop_pkg::rob_idx_t'(i) < enq_idx);
                end else begin
                    squash_mask[i] = (rob_uop_pkg::rob_idx_t'(i) > flush_idx) ||
                                     (rob_uop_pkg::rob_idx_t'(i) < enq_idx);
                end
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            walk_ptr <= '0;
        end else if (state == rob_ctrl_pkg::rollback) begin
            walk_ptr <= deq_ptr[`ROB_IDX_W-1:0];  // start from the oldest survivor
        end else if (state == rob_ctrl_pkg::walk) begin
            walk_ptr <= walk_ptr + 2'd2;
        end
    end

    assign walk_idx = walk_ptr;
    assign in_walk  = (state == rob_ctrl_pkg::walk);

    // only entries with a destination touch the rename table
    always_comb begin
        walk0.valid    = in_walk && walk0_view.valid && walk0_view.uop.need_to_wb;
        walk0.lrd      = walk0_view.uop.lrd;
        walk0.prd      = walk0_view.uop.prd;
        walk0.complete = walk0_view.complete;
        walk1.valid    = in_walk && walk1_view.valid && walk1_view.uop.need_to_wb;
        walk1.lrd      = walk1_view.uop.lrd;
        walk1.prd      = walk1_view.uop.prd;
        walk1.complete = walk1_view.complete;
    end

endmodule

`default_nettype wire

/* hw/rob_settings.svh */
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// queue geometry
`define ROB_DEPTH 64
`define ROB_IDX_W 6   // log2 of ROB_DEPTH

// payload field widths
`define PC_W      32
`define INSTR_W   32
`define LREG_W    5
`define PREG_W    7

`endif

/* hw/rob_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rob_settings.svh"

module rob_top (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire rob_uop_pkg::enq_lane_t  enq0,
    input  wire rob_uop_pkg::enq_lane_t  enq1,
    input  wire rob_ctrl_pkg::wb_port_t  int_wb,
    input  wire rob_ctrl_pkg::wb_port_t  mem_wb,
    input  wire rob_ctrl_pkg::flush_req_t flush,
    output rob_uop_pkg::robid_t          disp_robid,
    output rob_uop_pkg::commit_t         commit,
    output rob_ctrl_pkg::walk_lane_t     walk0,
    output rob_ctrl_pkg::walk_lane_t     walk1,
    output rob_ctrl_pkg::rob_state_e     rob_state
);

    logic                      wr0;
    logic                      wr1;
    rob_uop_pkg::rob_idx_t     wr0_idx;
    rob_uop_pkg::rob_idx_t     wr1_idx;
    rob_uop_pkg::robid_t       enq_ptr;
    rob_uop_pkg::robid_t       deq_ptr;
    rob_uop_pkg::robid_t       restore_robid;
    logic                      retire;
    logic [`ROB_DEPTH-1:0]     squash_mask;
    rob_uop_pkg::rob_idx_t     walk_idx;
    rob_ctrl_pkg::entry_view_t head_view;
    rob_ctrl_pkg::entry_view_t walk0_view;
    rob_ctrl_pkg::entry_view_t walk1_view;

    assign disp_robid = enq_ptr;  // next free slot for the dispatcher

    rob_enq_ctrl u_enq (
        .clock(clock), .reset_n(reset_n),
        .enq0(enq0), .enq1(enq1),
        .state(rob_state), .restore_robid(restore_robid),
        .wr0(wr0), .wr1(wr1), .wr0_idx(wr0_idx), .wr1_idx(wr1_idx),
        .enq_ptr(enq_ptr)
    );

    rob_entry_array u_array (
        .clock(clock), .reset_n(reset_n),
        .wr0(wr0), .wr1(wr1), .wr0_idx(wr0_idx), .wr1_idx(wr1_idx),
        .wr0_uop(enq0.uop), .wr1_uop(enq1.uop),
        .int_wb(int_wb), .mem_wb(mem_wb),
        .retire(retire), .retire_idx(deq_ptr[`ROB_IDX_W-1:0]),
        .squash_mask(squash_mask),
        .head_idx(deq_ptr[`ROB_IDX_W-1:0]), .walk_idx(walk_idx),
        .head_view(head_view), .walk0_view(walk0_view), .walk1_view(walk1_view)
    );

    rob_commit_ctrl u_commit (
        .clock(clock), .reset_n(reset_n),
        .head_view(head_view), .state(rob_state), .flush_valid(flush.valid),
        .deq_ptr(deq_ptr), .commit(commit), .retire(retire)
    );

    rob_flush_walk u_flush (
        .clock(clock), .reset_n(reset_n),
        .flush(flush), .enq_ptr(enq_ptr), .deq_ptr(deq_ptr),
        .walk0_view(walk0_view), .walk1_view(walk1_view),
        .state(rob_state), .restore_robid(restore_robid),
        .squash_mask(squash_mask), .walk_idx(walk_idx),
        .walk0(walk0), .walk1(walk1)
    );

endmodule

`default_nettype wire

/* hw/rob_uop_pkg.sv */
`default_nettype none

`include "rob_settings.svh"

package rob_uop_pkg;

    typedef logic [`PC_W-1:0]      pc_t;
    typedef logic [`INSTR_W-1:0]   instr_t;
    typedef logic [`LREG_W-1:0]    lreg_t;
    typedef logic [`PREG_W-1:0]    preg_t;
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [`ROB_IDX_W:0]   robid_t;   // index plus wrap bit on top

    // renamed instruction as it sits in an entry
    typedef struct packed {
        pc_t    pc;
        instr_t instr;
        lreg_t  lrd;
        preg_t  prd;
        preg_t  old_prd;     // freed once this entry retires
        logic   need_to_wb;  // has a destination register
    } uop_t;

    typedef struct packed {
        logic valid;
        uop_t uop;
    } enq_lane_t;

    typedef struct packed {
        logic   valid;
        uop_t   uop;
        robid_t robid;  // store queue wakeup
        logic   skip;   // mmio access, not checked against a model
    } commit_t;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f all.f --top-module rob_tb \
    -Mdir obj_dir -o rob_sim

./obj_dir/rob_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
grep -q "sim passed" sim.log
